/* logic/vlsu_sseg_settings.svh */
// field widths and sew codes for the segment-access control block, pulled in by `include
`ifndef VLSU_SSEG_SETTINGS_SVH
`define VLSU_SSEG_SETTINGS_SVH

// instruction context
`define SSEG_NF_W     3
`define SSEG_SEW_W    2
`define SSEG_FLD_W    2

// split count, round field on top of the count field
`define SSEG_CNT_W    10
`define SSEG_ROUND_W  2

// one-hot port select per lane
`define SSEG_SEL_W    4

// element width codes
`define SEW_BYTE      2'b00
`define SEW_HALF      2'b01
`define SEW_WORD      2'b10
`define SEW_DWORD     2'b11

`endif

/* logic/vlsu_sseg_pkg.sv */
// types shared by the segment-access control RTL and its testbench, import with ::*
`include "vlsu_sseg_settings.svh"

package vlsu_sseg_pkg;

  // bit 3 set means a segment sequence owns the buffer
  typedef enum logic [3:0] {
    IDLE      = 4'b0000,
    EXPT_IDLE = 4'b1000,
    MERGE     = 4'b1001,
    WB        = 4'b1010,
    FWD_PRE   = 4'b1100,
    FWD       = 4'b1101,
    WAIT      = 4'b1110,
    EXPT      = 4'b1111
  } sseg_state_e;

  // round tells instructions apart, cnt orders splits within one
  typedef struct packed {
    logic [`SSEG_ROUND_W-1:0]             round;
    logic [`SSEG_CNT_W-`SSEG_ROUND_W-1:0] cnt;
  } split_cnt_t;

  // dc stage create request
  typedef struct packed {
    logic                   create;
    logic                   sseg_first;
    logic                   fof;
    logic                   stall;
    logic [`SSEG_NF_W-1:0]  nf;
    logic [`SSEG_SEW_W-1:0] sew;
    split_cnt_t             split_cnt;
  } dc_req_t;

  // da stage load response
  typedef struct packed {
    logic data_vld;
    logic inst_fls;
    logic expt_vld;
    logic vl_update;
    logic split_last;
  } da_resp_t;

  // segment buffer status
  typedef struct packed {
    logic                     all_vld;
    logic                     all_wb;
    logic                     next_ready;
    logic                     fwd_pre;
    logic                     fwd_start;
    logic [`SSEG_ROUND_W-1:0] round;
  } vtb_stat_t;

  typedef struct packed {
    logic       vld;
    split_cnt_t cnt;
  } vtb_cnt_t;

  // what the FSM exposes to its neighbours
  typedef struct packed {
    sseg_state_e              state;
    logic [`SSEG_NF_W-1:0]    nf;
    logic [`SSEG_SEW_W-1:0]   sew;
    logic [`SSEG_FLD_W-1:0]   fld_cnt;
    logic [`SSEG_ROUND_W-1:0] round;
  } sseg_ctx_t;

  typedef struct packed {
    logic [`SSEG_SEL_W-1:0] sel0;
    logic [`SSEG_SEL_W-1:0] sel1;
    logic [`SSEG_SEL_W-1:0] sel2;
    logic [`SSEG_SEL_W-1:0] sel3;
  } port_sel_t;

endpackage

/* logic/sseg_lsu_intake.sv */
// load response intake, classifies create requests and holds the fof and exception flags
module sseg_lsu_intake
  import vlsu_sseg_pkg::*;
(
  input  logic     sseg_fsm_clk,
  input  logic     cpurst_b,
  input  logic     flush,
  input  dc_req_t  dc,
  input  da_resp_t da,
  input  logic     sseg_active,
  output logic     merge_start,
  output logic     start_type,
  output logic     abnormal_vld,
  output logic     abnormal_ff,
  output logic     wb_abnormal
);

  logic data_vld_masked;
  logic vl_update_eff;
  logic fof_mask_ff;
  logic expt_ff;

  //==========================================================================
  // create classification
  //==========================================================================
  // nf of 1..3 fields goes through the segment FSM
  assign start_type  = !dc.nf[2] && |dc.nf[1:0];
  assign merge_start = dc.create && dc.sseg_first && start_type;

  //==========================================================================
  // fof and exception tracking
  //==========================================================================
  // drop further data once the sequence has gone abnormal
  assign data_vld_masked = da.data_vld && !(abnormal_ff && sseg_active);
  assign vl_update_eff   = da.data_vld && !da.inst_fls && da.vl_update && !fof_mask_ff;

  // fof mask holds until the last split of the instruction
  always_ff @(posedge sseg_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      fof_mask_ff <= 1'b0;
    else if (da.data_vld && !da.inst_fls && da.split_last)
      fof_mask_ff <= 1'b0;
    else if (vl_update_eff)
      fof_mask_ff <= 1'b1;
  end

  // exception sticks until flush
  always_ff @(posedge sseg_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      expt_ff <= 1'b0;
    else if (flush)
      expt_ff <= 1'b0;
    else if (data_vld_masked && !da.inst_fls && da.expt_vld)
      expt_ff <= 1'b1;
  end

  assign abnormal_vld = data_vld_masked && !da.inst_fls && (vl_update_eff || da.expt_vld);
  assign abnormal_ff  = fof_mask_ff || expt_ff;

  // plain writeback path only reports abnormal outside a segment sequence
  assign wb_abnormal = (abnormal_vld || abnormal_ff) && !sseg_active;

  a_flush_clears_expt: assert property (@(posedge sseg_fsm_clk) disable iff (!cpurst_b)
    flush |=> !expt_ff);

endmodule

/* logic/sseg_ctrl_fsm.sv */
// segment FSM for load merges and store forwards, with field counter and captured context
`include "vlsu_sseg_settings.svh"

module sseg_ctrl_fsm
  import vlsu_sseg_pkg::*;
(
  input  logic                   sseg_fsm_clk,
  input  logic                   cpurst_b,
  input  logic                   flush,
  input  dc_req_t                dc,
  input  vtb_stat_t              vtb,
  input  logic [`SSEG_NF_W-1:0]  vtb_nf,
  input  logic [`SSEG_SEW_W-1:0] vtb_sew,
  input  logic                   merge_start,
  input  logic                   abnormal_vld,
  input  logic                   abnormal_ff,
  input  logic                   merge_vld,
  input  logic                   fwd_next,
  output sseg_ctx_t              ctx,
  output logic                   last_merge,
  output logic                   trans_up,
  output logic                   start_now,
  output logic                   sseg_vld,
  output logic                   fwd_vld,
  output logic                   wb_vld,
  output logic                   abnormal_out,
  output logic [`SSEG_NF_W-1:0]  sseg_nf
);

  sseg_state_e              cur_state;
  sseg_state_e              next_state;
  logic [`SSEG_NF_W-1:0]    nf;
  logic [`SSEG_SEW_W-1:0]   sew;
  logic [`SSEG_ROUND_W-1:0] round;
  logic [`SSEG_FLD_W-1:0]   fld_cnt;
  logic                     active;
  logic                     next_inst;
  logic                     nf3_part;

  assign active    = cur_state[3];
  assign start_now = (merge_start || vtb.fwd_pre || vtb.fwd_start) && !active;
  assign next_inst = (round != dc.split_cnt.round);

  //==========================================================================
  // state machine
  //==========================================================================
  always_ff @(posedge sseg_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= IDLE;
    else if (flush)
      cur_state <= IDLE;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      IDLE:
      begin
        if (vtb.fwd_start)
          next_state = FWD;
        else if (vtb.fwd_pre)
          next_state = FWD_PRE;
        else if (merge_start && !dc.stall)
          next_state = MERGE;
      end
      MERGE:
      begin
        if (merge_vld && last_merge)
          next_state = WB;
        else if (abnormal_vld)
          next_state = WAIT;
      end
      WB:
      begin
        if (vtb.next_ready)
          next_state = IDLE;
      end
      FWD_PRE:
      begin
        if (vtb.fwd_start)
          next_state = FWD;
      end
      FWD:
      begin
        if (fwd_next && last_merge)
          next_state = IDLE;
      end
      // hold until the buffer has the original values back
      WAIT:
      begin
        if (vtb.all_vld)
          next_state = EXPT;
      end
      EXPT:
      begin
        if (vtb.all_wb && abnormal_ff)
          next_state = EXPT_IDLE;
        else if (vtb.all_wb)
          next_state = IDLE;
      end
      // remaining splits of the same instruction still drain through WAIT
      EXPT_IDLE:
      begin
        if (!abnormal_ff)
          next_state = IDLE;
        else if (merge_start && !dc.stall && !next_inst)
          next_state = WAIT;
      end
      default: next_state = IDLE;
    endcase
  end

  //==========================================================================
  // context capture and field counter
  //==========================================================================
  // store forward takes its shape from the buffer, loads from the request
  always_ff @(posedge sseg_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      nf    <= '0;
      sew   <= '0;
      round <= '0;
    end
    else if (start_now)
    begin
      nf    <= vtb.fwd_pre ? vtb_nf : dc.nf;
      sew   <= vtb.fwd_pre ? vtb_sew : dc.sew;
      round <= dc.split_cnt.round;
    end
  end

  always_ff @(posedge sseg_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      fld_cnt <= '0;
    else if (start_now)
      fld_cnt <= '0;
    else if (merge_vld || fwd_next)
      fld_cnt <= fld_cnt + 1'b1;
  end

  // three small fields pack into 48 bits per merge, four merges needed
  assign nf3_part   = (nf == 3'd2) && !sew[1];
  assign last_merge = nf3_part ? (&fld_cnt) : (fld_cnt == nf[1:0]);

  assign trans_up = start_now || merge_vld || abnormal_vld || fwd_next
                    || ((cur_state == WAIT) && vtb.all_vld);

  assign ctx = '{state: cur_state, nf: nf, sew: sew, fld_cnt: fld_cnt, round: round};

  // status decodes
  assign sseg_vld     = active;
  assign fwd_vld      = (cur_state == FWD);
  assign wb_vld       = (cur_state == WB) && vtb.all_vld;
  assign abnormal_out = (cur_state == EXPT);
  assign sseg_nf      = nf;

  a_state_legal: assert property (@(posedge sseg_fsm_clk) disable iff (!cpurst_b)
    cur_state inside {IDLE, EXPT_IDLE, MERGE, WB, FWD_PRE, FWD, WAIT, EXPT});

endmodule

/* logic/sseg_port_sel.sv */
// registered lookup of the four segment buffer port selects, one cycle behind trans_up
`include "vlsu_sseg_settings.svh"

module sseg_port_sel
  import vlsu_sseg_pkg::*;
(
  input  logic                   sseg_fsm_clk,
  input  logic                   cpurst_b,
  input  sseg_ctx_t              ctx,
  input  logic                   start_now,
  input  logic                   trans_up,
  input  logic                   merge_vld,
  input  logic                   fwd_next,
  input  logic [`SSEG_NF_W-1:0]  dc_nf,
  input  logic [`SSEG_SEW_W-1:0] dc_sew,
  input  logic                   vtb_fwd_pre,
  input  logic [`SSEG_NF_W-1:0]  vtb_nf,
  input  logic [`SSEG_SEW_W-1:0] vtb_sew,
  output port_sel_t              sel
);

  logic [`SSEG_NF_W-1:0]  nf_next;
  logic [`SSEG_SEW_W-1:0] sew_next;
  logic [`SSEG_FLD_W-1:0] cnt_next;
  port_sel_t              sel_next;

  // look one cycle ahead so the registered select lines up with the data
  assign nf_next  = start_now ? (vtb_fwd_pre ? vtb_nf : dc_nf) : ctx.nf;
  assign sew_next = start_now ? (vtb_fwd_pre ? vtb_sew : dc_sew) : ctx.sew;
  assign cnt_next = start_now ? '0
                  : (merge_vld || fwd_next) ? ctx.fld_cnt + 1'b1
                  : ctx.fld_cnt;

  //==========================================================================
  // select table, lanes sel0..sel3 from high nibble down
  //==========================================================================
  always_comb
  begin
    sel_next = '0;
    case (sew_next)
      `SEW_BYTE, `SEW_HALF:
      begin
        case ({nf_next, cnt_next})
          {3'd1, 2'd0}: sel_next = 16'h1122;
          {3'd1, 2'd1}: sel_next = 16'h2211;
          // partial fields rotate through all four merges
          {3'd2, 2'd0}: sel_next = 16'h1402;
          {3'd2, 2'd1}: sel_next = 16'h4120;
          {3'd2, 2'd2}: sel_next = 16'h0214;
          {3'd2, 2'd3}: sel_next = 16'h2041;
          {3'd3, 2'd0}: sel_next = 16'h1482;
          {3'd3, 2'd1}: sel_next = 16'h4128;
          {3'd3, 2'd2}: sel_next = 16'h8214;
          {3'd3, 2'd3}: sel_next = 16'h2841;
          default:      sel_next = '0;
        endcase
      end
      `SEW_WORD:
      begin
        case ({nf_next, cnt_next})
          {3'd1, 2'd0}: sel_next = 16'h1122;
          {3'd1, 2'd1}: sel_next = 16'h2211;
          {3'd2, 2'd0}: sel_next = 16'h1122;
          {3'd2, 2'd1}: sel_next = 16'h4411;
          {3'd2, 2'd2}: sel_next = 16'h2244;
          {3'd3, 2'd0}: sel_next = 16'h1122;
          {3'd3, 2'd1}: sel_next = 16'h4488;
          {3'd3, 2'd2}: sel_next = 16'h2211;
          {3'd3, 2'd3}: sel_next = 16'h8844;
          default:      sel_next = '0;
        endcase
      end
      // dword elements need no lane steering
      `SEW_DWORD: sel_next = '0;
      default:    sel_next = '0;
    endcase
  end

  always_ff @(posedge sseg_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sel <= '0;
    else if (trans_up)
      sel <= sel_next;
  end

  // each lane reads at most one buffer port
  a_sel_onehot0: assert property (@(posedge sseg_fsm_clk) disable iff (!cpurst_b)
    $onehot0(sel.sel0) && $onehot0(sel.sel1) && $onehot0(sel.sel2) && $onehot0(sel.sel3));

endmodule

/* logic/sseg_pipe_stall.sv */
// buffer stall and split pause from split-count sync between the lsu and the segment buffer
`include "vlsu_sseg_settings.svh"

module sseg_pipe_stall
  import vlsu_sseg_pkg::*;
(
  input  dc_req_t                  dc,
  input  vtb_cnt_t                 cnt0,
  input  vtb_cnt_t                 cnt1,
  input  logic                     fof_vld,
  input  logic                     fld_stall,
  input  logic [`SSEG_ROUND_W-1:0] vtb_round,
  input  sseg_ctx_t                ctx,
  input  logic                     merge_start,
  input  logic                     start_type,
  output logic                     buf_stall,
  output logic                     split_pause
);

  logic vtb_ready;
  logic next_inst;
  logic expt_idle;
  logic full;

  // the lsu may run ahead only within its own round, and only for unit fields
  function automatic logic slot_ready(input vtb_cnt_t slot, input dc_req_t req);
    logic same_round;
    logic cnt_eq;
    logic cnt_gt;
    same_round = (slot.cnt.round == req.split_cnt.round);
    cnt_eq     = (slot.cnt.cnt == req.split_cnt.cnt);
    cnt_gt     = (slot.cnt.cnt > req.split_cnt.cnt);
    return slot.vld && same_round && (cnt_eq || (cnt_gt && !req.nf[2]));
  endfunction

  assign vtb_ready = slot_ready(cnt0, dc) || slot_ready(cnt1, dc);
  assign next_inst = (ctx.round != dc.split_cnt.round);
  assign expt_idle = (ctx.state == EXPT_IDLE);

  // a new segment start needs the whole buffer
  assign full = merge_start
                && !(expt_idle && !next_inst)
                && (ctx.state[3] || (dc.fof && !fof_vld) || cnt0.vld || cnt1.vld);

  assign buf_stall = full
                     || (dc.create && !start_type && !vtb_ready)
                     || fld_stall;

  // hold splits until the buffer moves on from the faulting round
  assign split_pause = (ctx.state == EXPT) || (expt_idle && (vtb_round != ctx.round));

endmodule

/* logic/vlsu_sseg_top.sv */
// top of the segment-access control block, connects intake, FSM, port select and stall logic
`include "vlsu_sseg_settings.svh"

module vlsu_sseg_top
  import vlsu_sseg_pkg::*;
(
  input  logic                     sseg_fsm_clk,
  input  logic                     cpurst_b,
  input  logic                     flush,
  input  dc_req_t                  dc,
  input  da_resp_t                 da,
  input  vtb_stat_t                vtb,
  input  logic [`SSEG_NF_W-1:0]    vtb_nf,
  input  logic [`SSEG_SEW_W-1:0]   vtb_sew,
  input  vtb_cnt_t                 cnt0,
  input  vtb_cnt_t                 cnt1,
  input  logic                     fof_vld,
  input  logic                     fld_stall,
  input  logic                     merge_vld,
  input  logic                     fwd_next,
  output port_sel_t                sel,
  output logic                     sseg_vld,
  output logic                     fwd_vld,
  output logic                     fwd_last,
  output logic                     wb_vld,
  output logic                     abnormal_out,
  output logic [`SSEG_NF_W-1:0]    sseg_nf,
  output logic                     wb_abnormal,
  output logic                     buf_stall,
  output logic                     split_pause
);

  logic      merge_start;
  logic      start_type;
  logic      abnormal_vld;
  logic      abnormal_ff;
  logic      trans_up;
  logic      start_now;
  sseg_ctx_t ctx;

  sseg_lsu_intake u_intake (
    .sseg_fsm_clk (sseg_fsm_clk), .cpurst_b (cpurst_b), .flush (flush),
    .dc (dc), .da (da), .sseg_active (sseg_vld),
    .merge_start (merge_start), .start_type (start_type),
    .abnormal_vld (abnormal_vld), .abnormal_ff (abnormal_ff), .wb_abnormal (wb_abnormal)
  );

  sseg_ctrl_fsm u_fsm (
    .sseg_fsm_clk (sseg_fsm_clk), .cpurst_b (cpurst_b), .flush (flush),
    .dc (dc), .vtb (vtb), .vtb_nf (vtb_nf), .vtb_sew (vtb_sew),
    .merge_start (merge_start), .abnormal_vld (abnormal_vld), .abnormal_ff (abnormal_ff),
    .merge_vld (merge_vld), .fwd_next (fwd_next),
    .ctx (ctx), .last_merge (fwd_last), .trans_up (trans_up), .start_now (start_now),
    .sseg_vld (sseg_vld), .fwd_vld (fwd_vld), .wb_vld (wb_vld),
    .abnormal_out (abnormal_out), .sseg_nf (sseg_nf)
  );

  sseg_port_sel u_port_sel (
    .sseg_fsm_clk (sseg_fsm_clk), .cpurst_b (cpurst_b), .ctx (ctx),
    .start_now (start_now), .trans_up (trans_up),
    .merge_vld (merge_vld), .fwd_next (fwd_next),
    .dc_nf (dc.nf), .dc_sew (dc.sew),
    .vtb_fwd_pre (vtb.fwd_pre), .vtb_nf (vtb_nf), .vtb_sew (vtb_sew),
    .sel (sel)
  );

  sseg_pipe_stall u_stall (
    .dc (dc), .cnt0 (cnt0), .cnt1 (cnt1), .fof_vld (fof_vld), .fld_stall (fld_stall),
    .vtb_round (vtb.round), .ctx (ctx),
    .merge_start (merge_start), .start_type (start_type),
    .buf_stall (buf_stall), .split_pause (split_pause)
  );

endmodule

/* verification/vlsu_sseg_tb.sv */
// random segment-sequence testbench for vlsu_sseg_top that checks every cycle against a cycle model
`include "vlsu_sseg_settings.svh"

module vlsu_sseg_tb
  import vlsu_sseg_pkg::*;
();

  localparam int M_IDLE  = 0;
  localparam int M_MERGE = 1;
  localparam int M_FWD   = 2;
  localparam int M_EXPT  = 3;
  localparam int M_FLUSH = 4;
  localparam int M_RAND  = 5;

  // four merges per nf row with lanes sel0..sel3 from the high nibble down
  localparam logic [15:0] SMALL_ROWS [0:11] = '{
    16'h1122, 16'h2211, 16'h0000, 16'h0000,
    16'h1402, 16'h4120, 16'h0214, 16'h2041,
    16'h1482, 16'h4128, 16'h8214, 16'h2841};
  localparam logic [15:0] WORD_ROWS [0:11] = '{
    16'h1122, 16'h2211, 16'h0000, 16'h0000,
    16'h1122, 16'h4411, 16'h2244, 16'h0000,
    16'h1122, 16'h4488, 16'h2211, 16'h8844};

  logic                     sseg_fsm_clk;
  logic                     cpurst_b;
  logic                     flush;
  dc_req_t                  dc;
  da_resp_t                 da;
  vtb_stat_t                vtb;
  logic [`SSEG_NF_W-1:0]    vtb_nf;
  logic [`SSEG_SEW_W-1:0]   vtb_sew;
  vtb_cnt_t                 cnt0;
  vtb_cnt_t                 cnt1;
  logic                     fof_vld;
  logic                     fld_stall;
  logic                     merge_vld;
  logic                     fwd_next;
  port_sel_t                sel;
  logic                     sseg_vld;
  logic                     fwd_vld;
  logic                     fwd_last;
  logic                     wb_vld;
  logic                     abnormal_out;
  logic [`SSEG_NF_W-1:0]    sseg_nf;
  logic                     wb_abnormal;
  logic                     buf_stall;
  logic                     split_pause;

  // cycle model state
  sseg_state_e              m_st;
  logic [`SSEG_NF_W-1:0]    m_nf;
  logic [`SSEG_SEW_W-1:0]   m_sew;
  logic [`SSEG_ROUND_W-1:0] m_round;
  logic [`SSEG_FLD_W-1:0]   m_fld;
  logic                     m_fof_mask;
  logic                     m_expt;
  logic [15:0]              m_sel;

  logic [31:0]              rng_state;
  int                       mode;
  int                       errors;
  logic [`SSEG_NF_W-1:0]    goal_nf;
  logic [`SSEG_SEW_W-1:0]   goal_sew;
  logic                     goal_expt;
  string                    test_name;

  vlsu_sseg_top dut (.*);

  initial
  begin
    sseg_fsm_clk = 1'b0;
    forever #20 sseg_fsm_clk = ~sseg_fsm_clk;
  end

  //==========================================================================
  // helpers
  //==========================================================================
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [15:0] sel_lookup(input logic [2:0] nf, input logic [1:0] sew,
                                             input logic [1:0] c);
    int idx;
    idx = (int'(nf) - 1) * 4 + int'(c);
    if (nf == 3'd0 || nf[2] || sew == `SEW_DWORD)
      return 16'h0000;
    else if (sew == `SEW_WORD)
      return WORD_ROWS[idx];
    else
      return SMALL_ROWS[idx];
  endfunction

  // slot ready for the current request
  function automatic logic slot_hit(input vtb_cnt_t s);
    if (!s.vld || s.cnt.round != dc.split_cnt.round)
      return 1'b0;
    return (s.cnt.cnt == dc.split_cnt.cnt) || (s.cnt.cnt > dc.split_cnt.cnt && !dc.nf[2]);
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    assert (act_v === exp_v)
    else
    begin
      errors++;
      $display("[ERROR] %s %s expected 0x%0h actual 0x%0h", test_name, what, exp_v, act_v);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic clear_inputs();
    dc   = '0;
    da   = '0;
    vtb  = '0;
    cnt0 = '0;
    cnt1 = '0;
    {vtb_nf, vtb_sew, fof_vld, fld_stall, merge_vld, fwd_next, flush} = 10'd0;
  endtask

  //==========================================================================
  // model compares this cycle's outputs and then advances one clock
  //==========================================================================
  task automatic model_cycle();
    logic start_type_m;
    logic merge_start_m;
    logic active;
    logic abn_ff;
    logic masked_vld;
    logic vlu_eff;
    logic abn_vld;
    logic start_now_m;
    logic last_m;
    logic trans_m;
    logic next_inst;
    logic full;
    logic stall_m;
    logic pause_m;
    logic [2:0] nf_n;
    logic [1:0] sew_n;
    logic [1:0] cnt_n;
    sseg_state_e st_n;
    start_type_m  = !dc.nf[2] && (dc.nf[1:0] != 2'b00);
    merge_start_m = dc.create && dc.sseg_first && start_type_m;
    active        = m_st[3];
    abn_ff        = m_fof_mask || m_expt;
    masked_vld    = da.data_vld && !(abn_ff && active);
    vlu_eff       = da.data_vld && !da.inst_fls && da.vl_update && !m_fof_mask;
    abn_vld       = masked_vld && !da.inst_fls && (vlu_eff || da.expt_vld);
    start_now_m   = (merge_start_m || vtb.fwd_pre || vtb.fwd_start) && !active;
    last_m        = (m_nf == 3'd2 && !m_sew[1]) ? (m_fld == 2'd3) : (m_fld == m_nf[1:0]);
    trans_m       = start_now_m || merge_vld || abn_vld || fwd_next
                    || (m_st == WAIT && vtb.all_vld);
    next_inst     = (m_round != dc.split_cnt.round);
    full          = merge_start_m && !(m_st == EXPT_IDLE && !next_inst)
                    && (active || (dc.fof && !fof_vld) || cnt0.vld || cnt1.vld);
    stall_m       = full || (dc.create && !start_type_m && !(slot_hit(cnt0) || slot_hit(cnt1)))
                    || fld_stall;
    pause_m       = (m_st == EXPT) || (m_st == EXPT_IDLE && vtb.round != m_round);

    expect_eq("status", {active, m_st == FWD, last_m, m_st == WB && vtb.all_vld, m_st == EXPT,
                         (abn_vld || abn_ff) && !active, stall_m, pause_m},
              {sseg_vld, fwd_vld, fwd_last, wb_vld, abnormal_out, wb_abnormal, buf_stall,
               split_pause});
    expect_eq("sseg_nf", m_nf, sseg_nf);
    expect_eq("sel", m_sel, sel);

    st_n = m_st;
    case (m_st)
      IDLE:      st_n = vtb.fwd_start ? FWD : vtb.fwd_pre ? FWD_PRE
                        : (merge_start_m && !dc.stall) ? MERGE : IDLE;
      MERGE:     st_n = (merge_vld && last_m) ? WB : abn_vld ? WAIT : MERGE;
      WB:        st_n = vtb.next_ready ? IDLE : WB;
      FWD_PRE:   st_n = vtb.fwd_start ? FWD : FWD_PRE;
      FWD:       st_n = (fwd_next && last_m) ? IDLE : FWD;
      WAIT:      st_n = vtb.all_vld ? EXPT : WAIT;
      EXPT:      st_n = !vtb.all_wb ? EXPT : abn_ff ? EXPT_IDLE : IDLE;
      EXPT_IDLE: st_n = !abn_ff ? IDLE
                        : (merge_start_m && !dc.stall && !next_inst) ? WAIT : EXPT_IDLE;
      default:   st_n = IDLE;
    endcase

    nf_n  = start_now_m ? (vtb.fwd_pre ? vtb_nf : dc.nf) : m_nf;
    sew_n = start_now_m ? (vtb.fwd_pre ? vtb_sew : dc.sew) : m_sew;
    cnt_n = start_now_m ? 2'd0 : (merge_vld || fwd_next) ? m_fld + 2'd1 : m_fld;
    if (trans_m)
      m_sel = sel_lookup(nf_n, sew_n, cnt_n);
    if (start_now_m)
      m_round = dc.split_cnt.round;
    m_nf  = nf_n;
    m_sew = sew_n;
    m_fld = cnt_n;
    if (da.data_vld && !da.inst_fls && da.split_last)
      m_fof_mask = 1'b0;
    else if (vlu_eff)
      m_fof_mask = 1'b1;
    if (flush)
      m_expt = 1'b0;
    else if (masked_vld && !da.inst_fls && da.expt_vld)
      m_expt = 1'b1;
    m_st = flush ? IDLE : st_n;
  endtask

  //==========================================================================
  // stimulus biased by mode toward legal segment sequences
  //==========================================================================
  task automatic run_cycle();
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] r3;
    @(posedge sseg_fsm_clk);
    #2;
    r  = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    clear_inputs();
    if (mode != M_IDLE && mode != M_FLUSH)
    begin
      // background traffic that never starts a sequence by itself
      dc            = {r3[29:27], r3[15:0]};
      dc.sseg_first = 1'b0;
      dc.stall      = 1'b0;
      vtb.round     = r3[17:16];
      vtb_nf        = r3[20:18];
      vtb_sew       = r3[22:21];
      fof_vld       = r3[23];
      fld_stall     = (r3[26:24] == 3'd0);
    end
    case (mode)
      M_MERGE, M_EXPT:
      begin
        if (m_st == IDLE && r[0])
        begin
          dc.create     = 1'b1;
          dc.sseg_first = 1'b1;
          dc.nf         = goal_nf;
          dc.sew        = goal_sew;
          dc.stall      = (mode == M_MERGE) && (r[2:1] == 2'd0);
        end
        if (mode == M_MERGE)
        begin
          merge_vld      = (m_st == MERGE) && r[3];
          vtb.all_vld    = r[4];
          vtb.next_ready = (m_st == WB) && r[5];
        end
        else
        begin
          if ((m_st == MERGE || m_st == EXPT_IDLE) && r[3])
          begin
            da.data_vld   = 1'b1;
            da.expt_vld   = goal_expt;
            da.vl_update  = !goal_expt;
            da.split_last = (m_st == EXPT_IDLE) && (r[8:7] == 2'd0);
          end
          vtb.all_vld = (m_st == WAIT) && r[4];
          vtb.all_wb  = (m_st == EXPT) && r[5];
        end
      end
      M_FWD:
      begin
        vtb_nf        = goal_nf;
        vtb_sew       = goal_sew;
        vtb.fwd_pre   = (m_st == IDLE) && r[0];
        vtb.fwd_start = (m_st == FWD_PRE) && r[1];
        fwd_next      = (m_st == FWD) && r[2];
      end
      M_FLUSH: flush = 1'b1;
      M_RAND:
      begin
        dc             = {r2[18:16], r[15:0]};
        da             = r[20:16];
        vtb.all_vld    = r[21];
        vtb.all_wb     = r[22];
        vtb.next_ready = r[23];
        vtb.fwd_pre    = (r[26:24] == 3'd0);
        vtb.fwd_start  = (r[29:27] == 3'd0);
        merge_vld      = r[30];
        fwd_next       = r[31];
        flush          = (r2[31:28] == 4'd0);
      end
      default: ;
    endcase
    if (mode != M_IDLE && mode != M_FLUSH)
    begin
      // small counts often in the request round so ready compares hit
      dc.split_cnt.cnt[7:4] = 4'h0;
      cnt0.vld       = r2[0];
      cnt0.cnt.round = r2[1] ? dc.split_cnt.round : r2[3:2];
      cnt0.cnt.cnt   = {4'h0, r2[7:4]};
      cnt1.vld       = r2[8];
      cnt1.cnt.round = r2[9] ? dc.split_cnt.round : r2[11:10];
      cnt1.cnt.cnt   = {4'h0, r2[15:12]};
    end
    @(negedge sseg_fsm_clk);
    model_cycle();
  endtask

  task automatic wait_state(input sseg_state_e target);
    int n;
    n = 0;
    while (m_st != target && n < 200)
    begin
      run_cycle();
      n++;
    end
    if (m_st != target)
    begin
      $display("%s timed out waiting 200 cycles for state %s", test_name, target.name());
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  //==========================================================================
  // test sequence
  //==========================================================================
  initial
  begin
    rng_state  = 32'hf120;
    errors     = 0;
    mode       = M_IDLE;
    goal_nf    = 3'd1;
    goal_sew   = `SEW_BYTE;
    goal_expt  = 1'b0;
    test_name  = "reset_idle";
    cpurst_b   = 1'b0;
    clear_inputs();
    m_st       = IDLE;
    m_nf       = '0;
    m_sew      = '0;
    m_round    = '0;
    m_fld      = '0;
    m_fof_mask = 1'b0;
    m_expt     = 1'b0;
    m_sel      = '0;
    repeat (2) @(posedge sseg_fsm_clk);
    #2;
    cpurst_b = 1'b1;
    repeat (4) run_cycle();

    // every nf and sew as a load merge and then as a store forward
    for (int n = 1; n <= 3; n++)
    begin
      for (int s = 0; s < 4; s++)
      begin
        goal_nf   = n[2:0];
        goal_sew  = s[1:0];
        test_name = "merge";
        mode      = M_MERGE;
        wait_state(MERGE);
        wait_state(WB);
        wait_state(IDLE);
        test_name = "forward";
        mode      = M_FWD;
        wait_state(FWD_PRE);
        wait_state(FWD);
        wait_state(IDLE);
      end
    end

    test_name = "exception";
    mode      = M_EXPT;
    goal_expt = 1'b1;
    goal_nf   = 3'd3;
    goal_sew  = `SEW_HALF;
    wait_state(MERGE);
    wait_state(WAIT);
    wait_state(EXPT);
    wait_state(EXPT_IDLE);
    repeat (8) run_cycle();

    // exception flag only clears on flush
    test_name = "flush";
    mode      = M_FLUSH;
    run_cycle();
    mode      = M_IDLE;
    run_cycle();
    expect_eq("sseg_vld", 0, sseg_vld);

    test_name = "fof";
    mode      = M_EXPT;
    goal_expt = 1'b0;
    goal_nf   = 3'd2;
    goal_sew  = `SEW_BYTE;
    wait_state(MERGE);
    wait_state(WAIT);
    wait_state(EXPT);
    wait_state(EXPT_IDLE);
    wait_state(IDLE);

    test_name = "random";
    mode      = M_RAND;
    repeat (2000) run_cycle();

    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* vlsu_sseg.f */
+incdir+logic
logic/vlsu_sseg_pkg.sv
logic/sseg_lsu_intake.sv
logic/sseg_ctrl_fsm.sv
logic/sseg_port_sel.sv
logic/sseg_pipe_stall.sv
logic/vlsu_sseg_top.sv
verification/vlsu_sseg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the segment-access control testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=vlsu_sseg_sim

verilator --binary --timing --assert -Wno-fatal \
  -f vlsu_sseg.f --top-module vlsu_sseg_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
